// ==== verilog/riscv_v_settings.svh ====
//////////////////////////////////////////////////
// RISC-V vector bitwise lane settings
// Datapath geometry shared by package, RTL and bench
//////////////////////////////////////////////////

`ifndef RISCV_V_SETTINGS_SVH
`define RISCV_V_SETTINGS_SVH

// Bytes per datapath word
`define RISCV_V_NUM_BYTES_DATA 8

// Bits per byte
`define RISCV_V_BYTE_WIDTH 8

// Element sizes 8/16/32/64, log2 of byte count plus one
`define RISCV_V_NUM_OSIZE 4

`endif

// ==== verilog/riscv_v_pkg.sv ====
//////////////////////////////////////////////////
// RISC-V vector bitwise lane types
// Data words, valid masks, size vectors, enums
//////////////////////////////////////////////////

package riscv_v_pkg;

`include "riscv_v_settings.svh"

    // One data byte
    typedef logic [`RISCV_V_BYTE_WIDTH-1:0] riscv_v_byte_t;

    // Operand or result word, byte addressable
    typedef riscv_v_byte_t [`RISCV_V_NUM_BYTES_DATA-1:0] riscv_v_src_byte_vector_t;

    // One valid bit per byte
    typedef logic [`RISCV_V_NUM_BYTES_DATA-1:0] riscv_v_valid_t;

    // Element size code: 0 byte, 1 half, 2 word, 3 double
    typedef logic [$clog2(`RISCV_V_NUM_OSIZE)-1:0] riscv_v_osize_t;

    // Thermometer vectors that steer the reduction trees
    typedef logic [`RISCV_V_NUM_OSIZE-1:0] osize_vector_t;

    // Bitwise operator
    typedef enum logic [1:0] {
        BW_AND,
        BW_OR,
        BW_XOR
    } riscv_v_bw_op_e;

    // Controller handshake states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_ACK
    } riscv_v_bw_state_e;

endpackage : riscv_v_pkg

// ==== verilog/riscv_v_osize_decode.sv ====
//////////////////////////////////////////////////
// Element size decoder
// Expands the size code into thermometer vectors
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "riscv_v_settings.svh"

module riscv_v_osize_decode (
    input  riscv_v_pkg::riscv_v_osize_t osize,
    output riscv_v_pkg::osize_vector_t  osize_vector,
    output riscv_v_pkg::osize_vector_t  is_greater_osize_vector
);

    // Bit k of osize_vector: element wider than 2^k bytes
    // Bit k of is_greater_osize_vector: element at least 2^k bytes
    // e.g. word gives 0011 and 0111
    always_comb begin
        for (int k = 0; k < `RISCV_V_NUM_OSIZE; k++) begin
            osize_vector[k]            = (int'(osize) > k);
            is_greater_osize_vector[k] = (int'(osize) >= k);
        end
    end

endmodule : riscv_v_osize_decode

// ==== verilog/riscv_v_bw_and.sv ====
//////////////////////////////////////////////////
// Byte-wise AND block
// Element-wise AND and vredand through a byte tree
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "riscv_v_settings.svh"

module riscv_v_bw_and (
    input  logic                                  is_and,
    input  logic                                  is_reduct,
    input  logic                                  is_reduct_n,
    input  riscv_v_pkg::osize_vector_t            osize_vector,
    input  riscv_v_pkg::osize_vector_t            is_greater_osize_vector,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srca,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srcb,
    input  riscv_v_pkg::riscv_v_valid_t           srcb_valid,
    output riscv_v_pkg::riscv_v_src_byte_vector_t result
);
    import riscv_v_pkg::*;

    localparam int NUM_BW_BLOCKS = `RISCV_V_NUM_BYTES_DATA;
    localparam int NUM_LEVELS    = $clog2(`RISCV_V_NUM_BYTES_DATA);

    // AND identity, all ones, but forced low while idle
    riscv_v_byte_t ident;

    assign ident = {`RISCV_V_BYTE_WIDTH{is_and}};

    for (genvar b = 0; b < NUM_BW_BLOCKS; b++) begin : gen_bw_and
        riscv_v_byte_t                  srca_gated;
        riscv_v_byte_t                  srcb_gated;
        riscv_v_byte_t                  srca_bw;
        riscv_v_byte_t                  srcb_bw;
        riscv_v_byte_t                  res;
        logic                           srca_sel;
        riscv_v_byte_t [NUM_LEVELS-1:0] tap;

        // Sources gated by the operation select
        assign srca_gated = srca[b] & ident;
        assign srcb_gated = srcb[b] & ident;

        // srca enters only the bytes of element 0 in a reduction
        assign srca_sel = is_reduct_n | is_greater_osize_vector[$clog2(b + 1)];

        // Tree inputs from the byte 2^r above
        // Only levels at or above the element size, on aligned nodes
        for (genvar r = 0; r < NUM_LEVELS; r++) begin : gen_tap
            if (b + 2**r < NUM_BW_BLOCKS) begin : gen_link
                logic tap_en;

                assign tap_en = is_reduct & ~osize_vector[r]
                              & is_greater_osize_vector[$clog2(b % 2**(r + 1) + 1)];
                assign tap[r] = tap_en ? gen_bw_and[b + 2**r].res : ident;
            end else begin : gen_leaf
                assign tap[r] = ident;
            end
        end

        // Fold srca slot and tree inputs
        always_comb begin
            srca_bw = srca_sel ? srca_gated : ident;
            for (int r = 0; r < NUM_LEVELS; r++) begin
                srca_bw &= tap[r];
            end
        end

        // Invalid srcb bytes become all ones, no effect on the fold
        assign srcb_bw = srcb_valid[b] ? srcb_gated : ident;

        assign res       = srca_bw & srcb_bw;
        assign result[b] = res;
    end

endmodule : riscv_v_bw_and

// ==== verilog/riscv_v_bw_or.sv ====
//////////////////////////////////////////////////
// Byte-wise OR block
// Element-wise OR and vredor through a byte tree
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "riscv_v_settings.svh"

module riscv_v_bw_or (
    input  logic                                  is_or,
    input  logic                                  is_reduct,
    input  logic                                  is_reduct_n,
    input  riscv_v_pkg::osize_vector_t            osize_vector,
    input  riscv_v_pkg::osize_vector_t            is_greater_osize_vector,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srca,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srcb,
    input  riscv_v_pkg::riscv_v_valid_t           srcb_valid,
    output riscv_v_pkg::riscv_v_src_byte_vector_t result
);
    import riscv_v_pkg::*;

    localparam int NUM_BW_BLOCKS = `RISCV_V_NUM_BYTES_DATA;
    localparam int NUM_LEVELS    = $clog2(`RISCV_V_NUM_BYTES_DATA);

    for (genvar b = 0; b < NUM_BW_BLOCKS; b++) begin : gen_bw_or
        riscv_v_byte_t                  srca_gated;
        riscv_v_byte_t                  srcb_gated;
        riscv_v_byte_t                  srca_bw;
        riscv_v_byte_t                  srcb_bw;
        riscv_v_byte_t                  res;
        logic                           srca_sel;
        riscv_v_byte_t [NUM_LEVELS-1:0] tap;

        // Idle block sees all zeros
        assign srca_gated = srca[b] & {`RISCV_V_BYTE_WIDTH{is_or}};
        assign srcb_gated = srcb[b] & {`RISCV_V_BYTE_WIDTH{is_or}};

        // srca slot kept only for element 0 bytes when reducing
        assign srca_sel = is_reduct_n | is_greater_osize_vector[$clog2(b + 1)];

        // Upper byte results feeding this node
        for (genvar r = 0; r < NUM_LEVELS; r++) begin : gen_tap
            if (b + 2**r < NUM_BW_BLOCKS) begin : gen_link
                logic tap_en;

                assign tap_en = is_reduct & ~osize_vector[r]
                              & is_greater_osize_vector[$clog2(b % 2**(r + 1) + 1)];
                assign tap[r] = gen_bw_or[b + 2**r].res
                              & {`RISCV_V_BYTE_WIDTH{tap_en}};
            end else begin : gen_leaf
                // Top of the chain, nothing above
                assign tap[r] = '0;
            end
        end

        always_comb begin
            srca_bw = srca_gated & {`RISCV_V_BYTE_WIDTH{srca_sel}};
            for (int r = 0; r < NUM_LEVELS; r++) begin
                srca_bw |= tap[r];
            end
        end

        // Zero is the OR identity for invalid bytes
        assign srcb_bw = srcb_gated & {`RISCV_V_BYTE_WIDTH{srcb_valid[b]}};

        assign res       = srca_bw | srcb_bw;
        assign result[b] = res;
    end

endmodule : riscv_v_bw_or

// ==== verilog/riscv_v_bw_xor.sv ====
//////////////////////////////////////////////////
// Byte-wise XOR block
// Element-wise XOR and vredxor through a byte tree
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "riscv_v_settings.svh"

module riscv_v_bw_xor (
    input  logic                                  is_xor,
    input  logic                                  is_reduct,
    input  logic                                  is_reduct_n,
    input  riscv_v_pkg::osize_vector_t            osize_vector,
    input  riscv_v_pkg::osize_vector_t            is_greater_osize_vector,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srca,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srcb,
    input  riscv_v_pkg::riscv_v_valid_t           srcb_valid,
    output riscv_v_pkg::riscv_v_src_byte_vector_t result
);
    import riscv_v_pkg::*;

    localparam int NUM_BW_BLOCKS = `RISCV_V_NUM_BYTES_DATA;
    localparam int NUM_LEVELS    = $clog2(`RISCV_V_NUM_BYTES_DATA);

    for (genvar b = 0; b < NUM_BW_BLOCKS; b++) begin : gen_bw_xor
        riscv_v_byte_t                  srca_gated;
        riscv_v_byte_t                  srcb_gated;
        riscv_v_byte_t                  srca_bw;
        riscv_v_byte_t                  srcb_bw;
        riscv_v_byte_t                  res;
        logic                           srca_sel;
        riscv_v_byte_t [NUM_LEVELS-1:0] tap;

        // Operation gating on both sources
        assign srca_gated = srca[b] & {`RISCV_V_BYTE_WIDTH{is_xor}};
        assign srcb_gated = srcb[b] & {`RISCV_V_BYTE_WIDTH{is_xor}};

        // Scalar from srca only lands in element 0
        assign srca_sel = is_reduct_n | is_greater_osize_vector[$clog2(b + 1)];

        // Binomial tree links, one per level
        for (genvar r = 0; r < NUM_LEVELS; r++) begin : gen_tap
            if (b + 2**r < NUM_BW_BLOCKS) begin : gen_link
                logic tap_en;

                assign tap_en = is_reduct & ~osize_vector[r]
                              & is_greater_osize_vector[$clog2(b % 2**(r + 1) + 1)];
                assign tap[r] = gen_bw_xor[b + 2**r].res
                              & {`RISCV_V_BYTE_WIDTH{tap_en}};
            end else begin : gen_leaf
                assign tap[r] = '0;
            end
        end

        always_comb begin
            srca_bw = srca_gated & {`RISCV_V_BYTE_WIDTH{srca_sel}};
            for (int r = 0; r < NUM_LEVELS; r++) begin
                srca_bw ^= tap[r];
            end
        end

        // Invalid bytes zeroed, XOR with zero is a no-op
        assign srcb_bw = srcb_gated & {`RISCV_V_BYTE_WIDTH{srcb_valid[b]}};

        assign res       = srca_bw ^ srcb_bw;
        assign result[b] = res;
    end

endmodule : riscv_v_bw_xor

// ==== verilog/riscv_v_bw_ctrl.sv ====
//////////////////////////////////////////////////
// Bitwise lane controller
// Four-phase req/ack FSM, operand capture, result
// select and reduction masking
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "riscv_v_settings.svh"

module riscv_v_bw_ctrl (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req,
    output logic                                  ack,
    input  riscv_v_pkg::riscv_v_bw_op_e           op,
    input  riscv_v_pkg::riscv_v_osize_t           osize,
    input  logic                                  is_reduct,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srca,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srcb,
    input  riscv_v_pkg::riscv_v_valid_t           srca_valid,
    input  riscv_v_pkg::riscv_v_valid_t           srcb_valid,
    output riscv_v_pkg::riscv_v_osize_t           r_osize,
    input  riscv_v_pkg::osize_vector_t            osize_vector,
    output logic                                  is_and,
    output logic                                  is_or,
    output logic                                  is_xor,
    output logic                                  r_is_reduct,
    output logic                                  r_is_reduct_n,
    output riscv_v_pkg::riscv_v_src_byte_vector_t r_srca,
    output riscv_v_pkg::riscv_v_src_byte_vector_t r_srcb,
    output riscv_v_pkg::riscv_v_valid_t           r_srcb_valid,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t and_result,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t or_result,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t xor_result,
    output riscv_v_pkg::riscv_v_src_byte_vector_t result,
    output riscv_v_pkg::riscv_v_valid_t           result_valid
);
    import riscv_v_pkg::*;

    riscv_v_bw_state_e        state;
    riscv_v_bw_op_e           r_op;
    riscv_v_valid_t           r_srca_valid;
    // Bytes of element 0 for the current size
    riscv_v_valid_t           low_valid;
    riscv_v_src_byte_vector_t sel_result;
    riscv_v_src_byte_vector_t result_mask;

    // IDLE -> CALC on req, CALC -> ACK, ACK -> IDLE once req drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (req) state <= ST_CALC;
                ST_CALC: state <= ST_ACK;
                ST_ACK:  if (!req) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign ack = (state == ST_ACK);

    // Operand capture on the IDLE -> CALC edge
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            r_op         <= op;
            r_osize      <= osize;
            r_is_reduct  <= is_reduct;
            r_srca       <= srca;
            r_srcb       <= srcb;
            r_srca_valid <= srca_valid;
            r_srcb_valid <= srcb_valid;
        end
    end

    // One-hot selects, live in CALC only so the blocks rest otherwise
    assign is_and        = (state == ST_CALC) && (r_op == BW_AND);
    assign is_or         = (state == ST_CALC) && (r_op == BW_OR);
    assign is_xor        = (state == ST_CALC) && (r_op == BW_XOR);
    assign r_is_reduct_n = ~r_is_reduct;

    // Byte b is in element 0 when the element is wider than its top bit
    assign low_valid[0] = 1'b1;
    for (genvar b = 1; b < `RISCV_V_NUM_BYTES_DATA; b++) begin : gen_low_valid
        assign low_valid[b] = osize_vector[$clog2(b + 1) - 1];
    end

    always_comb begin
        case (r_op)
            BW_AND:  sel_result = and_result;
            BW_OR:   sel_result = or_result;
            BW_XOR:  sel_result = xor_result;
            default: sel_result = '0;
        endcase
        // Reduction keeps element 0 only
        for (int i = 0; i < `RISCV_V_NUM_BYTES_DATA; i++) begin
            result_mask[i] = r_is_reduct ? {`RISCV_V_BYTE_WIDTH{low_valid[i]}} : '1;
        end
    end

    // Result held from CALC until the next operation
    always_ff @(posedge clk) begin
        if (state == ST_CALC) begin
            result       <= sel_result & result_mask;
            result_valid <= r_is_reduct ? low_valid : r_srca_valid;
        end
    end

endmodule : riscv_v_bw_ctrl

// ==== verilog/riscv_v_bw_unit.sv ====
//////////////////////////////////////////////////
// Bitwise slice of a RISC-V vector ALU lane
// Controller, size decoder and AND/OR/XOR blocks
//////////////////////////////////////////////////

`timescale 1ns/1ps

module riscv_v_bw_unit (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req,
    input  riscv_v_pkg::riscv_v_bw_op_e           op,
    input  logic                                  is_reduct,
    input  riscv_v_pkg::riscv_v_osize_t           osize,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srca,
    input  riscv_v_pkg::riscv_v_valid_t           srca_valid,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srcb,
    input  riscv_v_pkg::riscv_v_valid_t           srcb_valid,
    output logic                                  ack,
    output riscv_v_pkg::riscv_v_src_byte_vector_t result,
    output riscv_v_pkg::riscv_v_valid_t           result_valid
);
    import riscv_v_pkg::*;

    // Registered operands and selects from the controller
    riscv_v_osize_t           r_osize;
    logic                     is_and;
    logic                     is_or;
    logic                     is_xor;
    logic                     r_is_reduct;
    logic                     r_is_reduct_n;
    riscv_v_src_byte_vector_t r_srca;
    riscv_v_src_byte_vector_t r_srcb;
    riscv_v_valid_t           r_srcb_valid;
    // Size steering vectors
    osize_vector_t            osize_vector;
    osize_vector_t            is_greater_osize_vector;
    // Operator block outputs
    riscv_v_src_byte_vector_t and_result;
    riscv_v_src_byte_vector_t or_result;
    riscv_v_src_byte_vector_t xor_result;

    riscv_v_bw_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .ack           (ack),
        .op            (op),
        .osize         (osize),
        .is_reduct     (is_reduct),
        .srca          (srca),
        .srcb          (srcb),
        .srca_valid    (srca_valid),
        .srcb_valid    (srcb_valid),
        .r_osize       (r_osize),
        .osize_vector  (osize_vector),
        .is_and        (is_and),
        .is_or         (is_or),
        .is_xor        (is_xor),
        .r_is_reduct   (r_is_reduct),
        .r_is_reduct_n (r_is_reduct_n),
        .r_srca        (r_srca),
        .r_srcb        (r_srcb),
        .r_srcb_valid  (r_srcb_valid),
        .and_result    (and_result),
        .or_result     (or_result),
        .xor_result    (xor_result),
        .result        (result),
        .result_valid  (result_valid)
    );

    riscv_v_osize_decode u_osize_decode (
        .osize                   (r_osize),
        .osize_vector            (osize_vector),
        .is_greater_osize_vector (is_greater_osize_vector)
    );

    riscv_v_bw_and u_bw_and (
        .is_and                  (is_and),
        .is_reduct               (r_is_reduct),
        .is_reduct_n             (r_is_reduct_n),
        .osize_vector            (osize_vector),
        .is_greater_osize_vector (is_greater_osize_vector),
        .srca                    (r_srca),
        .srcb                    (r_srcb),
        .srcb_valid              (r_srcb_valid),
        .result                  (and_result)
    );

    riscv_v_bw_or u_bw_or (
        .is_or                   (is_or),
        .is_reduct               (r_is_reduct),
        .is_reduct_n             (r_is_reduct_n),
        .osize_vector            (osize_vector),
        .is_greater_osize_vector (is_greater_osize_vector),
        .srca                    (r_srca),
        .srcb                    (r_srcb),
        .srcb_valid              (r_srcb_valid),
        .result                  (or_result)
    );

    riscv_v_bw_xor u_bw_xor (
        .is_xor                  (is_xor),
        .is_reduct               (r_is_reduct),
        .is_reduct_n             (r_is_reduct_n),
        .osize_vector            (osize_vector),
        .is_greater_osize_vector (is_greater_osize_vector),
        .srca                    (r_srca),
        .srcb                    (r_srcb),
        .srcb_valid              (r_srcb_valid),
        .result                  (xor_result)
    );

endmodule : riscv_v_bw_unit

// ==== bench/riscv_v_bw_chk.sv ====
//////////////////////////////////////////////////
// Handshake and reset assertions for the bitwise
// lane, bound into riscv_v_bw_unit
//////////////////////////////////////////////////

`timescale 1ns/1ps

module riscv_v_bw_chk (
    input logic                                  clk,
    input logic                                  rst_n,
    input logic                                  req,
    input logic                                  ack,
    input riscv_v_pkg::riscv_v_src_byte_vector_t result,
    input riscv_v_pkg::riscv_v_valid_t           result_valid
);

    // Reset clears ack by the next edge
    a_reset_ack: assert property (@(posedge clk) !rst_n |=> !ack)
        else $error("ack is still high during reset");

    // Rise of ack only two cycles after a rise of req
    a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) == ($past(req, 2) && !$past(req, 3)))
        else $error("ack did not rise exactly two cycles after req");

    // Return to zero one cycle after req drops
    a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req) |=> !ack)
        else $error("ack did not fall one cycle after req");

    // Result held for the whole ack phase
    a_result_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ack && $past(ack) |-> $stable(result) && $stable(result_valid))
        else $error("result changed while ack was high");

endmodule : riscv_v_bw_chk

bind riscv_v_bw_unit riscv_v_bw_chk u_bw_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .ack          (ack),
    .result       (result),
    .result_valid (result_valid)
);

// ==== bench/riscv_v_bw_tb.sv ====
//////////////////////////////////////////////////
// Testbench for the RISC-V vector bitwise lane
// Table driven req/ack runs against a byte model
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "riscv_v_settings.svh"

module riscv_v_bw_tb;
    import riscv_v_pkg::*;

    localparam int          NUM_TESTS      = 24;
    localparam int          NUM_BYTES      = `RISCV_V_NUM_BYTES_DATA;
    localparam int          BYTE_W         = `RISCV_V_BYTE_WIDTH;
    localparam int          TIMEOUT_CYCLES = NUM_TESTS * 10 + 50;
    localparam logic [31:0] LFSR_SEED      = 32'ha04f_1e2a;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    typedef logic [NUM_BYTES*BYTE_W-1:0] word_t;

    logic                     clk;
    logic                     rst_n;
    logic                     req;
    riscv_v_bw_op_e           op;
    logic                     is_reduct;
    riscv_v_osize_t           osize;
    riscv_v_src_byte_vector_t srca;
    riscv_v_valid_t           srca_valid;
    riscv_v_src_byte_vector_t srcb;
    riscv_v_valid_t           srcb_valid;
    logic                     ack;
    riscv_v_src_byte_vector_t result;
    riscv_v_valid_t           result_valid;

    // Stimulus table, one slot per test
    string                    tbl_name       [NUM_TESTS];
    riscv_v_bw_op_e           tbl_op         [NUM_TESTS];
    logic                     tbl_red        [NUM_TESTS];
    riscv_v_osize_t           tbl_osize      [NUM_TESTS];
    word_t                    tbl_srca       [NUM_TESTS];
    word_t                    tbl_srcb       [NUM_TESTS];
    riscv_v_valid_t           tbl_srca_valid [NUM_TESTS];
    riscv_v_valid_t           tbl_srcb_valid [NUM_TESTS];
    // Extra cycles req stays high after ack
    int                       tbl_hold       [NUM_TESTS];

    int                       n_entries   = 0;
    int                       error_count = 0;
    int                       fail_count  = 0;
    int                       cycle_count = 0;
    logic                     test_failed;
    logic [31:0]              lfsr_state;

    riscv_v_bw_unit u_riscv_v_bw_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .op           (op),
        .is_reduct    (is_reduct),
        .osize        (osize),
        .srca         (srca),
        .srca_valid   (srca_valid),
        .srcb         (srcb),
        .srcb_valid   (srcb_valid),
        .ack          (ack),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog on the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the handshake never completed", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // Galois step, right shift with feedback taps
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic random_word(output word_t w);
        for (int k = 0; k < NUM_BYTES * BYTE_W; k++) begin
            w[k]       = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic word_t valid_to_mask(input riscv_v_valid_t v);
        word_t m;
        m = '0;
        for (int k = 0; k < NUM_BYTES; k++) begin
            m[k*BYTE_W +: BYTE_W] = {BYTE_W{v[k]}};
        end
        return m;
    endfunction

    function automatic word_t apply_op(input riscv_v_bw_op_e op_i, input word_t x, input word_t y);
        case (op_i)
            BW_AND:  return x & y;
            BW_OR:   return x | y;
            default: return x ^ y;
        endcase
    endfunction

    // Behavioral model of the result rule
    task automatic compute_expected(input riscv_v_bw_op_e op_i, input logic red,
                                    input riscv_v_osize_t sz, input word_t a, input word_t b,
                                    input riscv_v_valid_t a_valid,
                                    input riscv_v_valid_t b_valid,
                                    output word_t exp_res, output riscv_v_valid_t exp_valid);
        int             elem_bytes;
        riscv_v_valid_t elem_vmask;
        riscv_v_valid_t slot_vmask;
        word_t          elem_mask;
        word_t          acc;
        elem_bytes = 1 << sz;
        elem_vmask = '0;
        for (int k = 0; k < elem_bytes; k++) begin
            elem_vmask[k] = 1'b1;
        end
        elem_mask = valid_to_mask(elem_vmask);
        if (!red) begin
            exp_res   = apply_op(op_i, a, b);
            exp_valid = a_valid;
        end else begin
            // Scalar of srca folded with every fully valid srcb element
            acc = a & elem_mask;
            for (int j = 0; j < NUM_BYTES / elem_bytes; j++) begin
                slot_vmask = elem_vmask << (j * elem_bytes);
                if ((b_valid & slot_vmask) == slot_vmask) begin
                    acc = apply_op(op_i, acc, (b >> (j * elem_bytes * BYTE_W)) & elem_mask);
                end
            end
            exp_res   = acc;
            exp_valid = elem_vmask;
        end
    endtask

    task automatic check_value(input string test_name, input string what,
                               input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
            error_count++;
            test_failed = 1'b1;
        end
    endtask

    // rnd bit 0 draws srca, bit 1 draws srcb from the LFSR
    task automatic add_entry(input string name, input riscv_v_bw_op_e op_i, input int red,
                             input int sz, input word_t a, input word_t b,
                             input riscv_v_valid_t a_valid, input riscv_v_valid_t b_valid,
                             input int rnd, input int hold);
        word_t a_word;
        word_t b_word;
        a_word = a;
        b_word = b;
        if (rnd[0]) random_word(a_word);
        if (rnd[1]) random_word(b_word);
        tbl_name[n_entries]       = name;
        tbl_op[n_entries]         = op_i;
        tbl_red[n_entries]        = (red != 0);
        tbl_osize[n_entries]      = riscv_v_osize_t'(sz);
        tbl_srca[n_entries]       = a_word;
        tbl_srcb[n_entries]       = b_word;
        tbl_srca_valid[n_entries] = a_valid;
        tbl_srcb_valid[n_entries] = b_valid;
        tbl_hold[n_entries]       = hold;
        n_entries++;
    endtask

    // Columns: name, op, reduction, osize, srca, srcb, srca_valid, srcb_valid, rnd, hold
    task automatic build_table();
        lfsr_state = LFSR_SEED;
        add_entry("ew_and_b", BW_AND, 0, 0, 64'hf0f0_a5a5_3c3c_ff00,
                  64'h0ff0_5a5a_ffff_0f0f, 8'hff, 8'hff, 0, 0);
        add_entry("ew_or_h", BW_OR, 0, 1, 64'h0, 64'h0, 8'h3c, 8'hff, 3, 0);
        add_entry("ew_xor_w", BW_XOR, 0, 2, 64'h0, 64'h0, 8'hff, 8'hff, 3, 0);
        add_entry("ew_and_d_hold", BW_AND, 0, 3, 64'h0, 64'h0, 8'hff, 8'hff, 3, 4);
        add_entry("ew_or_b", BW_OR, 0, 0, 64'h8040_2010_0804_0201,
                  64'h0102_0408_1020_4080, 8'hff, 8'hff, 0, 0);
        add_entry("ew_xor_d", BW_XOR, 0, 3, 64'h0, 64'h0, 8'h0f, 8'hff, 3, 0);
        add_entry("red_and_b", BW_AND, 1, 0, 64'hffff_ffff_ffff_fff7,
                  64'hfeff_fffd_ffff_bfff, 8'hff, 8'hff, 0, 0);
        add_entry("red_and_h", BW_AND, 1, 1, 64'h0000_0000_0000_efff,
                  64'hfffe_7fff_ffdf_ffff, 8'hff, 8'hff, 0, 0);
        add_entry("red_and_w", BW_AND, 1, 2, 64'h0123_4567_f7ff_ffff,
                  64'hffff_fffe_bfff_ffff, 8'hff, 8'hff, 0, 2);
        add_entry("red_and_d", BW_AND, 1, 3, 64'h0, 64'h0, 8'hff, 8'hff, 3, 0);
        add_entry("red_or_b", BW_OR, 1, 0, 64'h0, 64'h8000_0400_0020_0001, 8'hff, 8'hff, 0, 0);
        add_entry("red_or_h", BW_OR, 1, 1, 64'h0, 64'h0010_0200_0003_4000, 8'hff, 8'hff, 1, 0);
        add_entry("red_or_w", BW_OR, 1, 2, 64'h0, 64'h0, 8'hff, 8'hff, 3, 0);
        add_entry("red_or_d_hold", BW_OR, 1, 3, 64'h0, 64'h0, 8'hff, 8'hff, 3, 2);
        add_entry("red_xor_b", BW_XOR, 1, 0, 64'h0, 64'h0, 8'hff, 8'hff, 3, 0);
        add_entry("red_xor_h", BW_XOR, 1, 1, 64'h0, 64'h0, 8'hff, 8'hff, 3, 1);
        add_entry("red_xor_w", BW_XOR, 1, 2, 64'h0, 64'h0, 8'hff, 8'hff, 3, 0);
        add_entry("red_xor_d", BW_XOR, 1, 3, 64'h0, 64'h0, 8'hff, 8'hff, 3, 0);
        // Zeros sit in the invalid bytes, so they must be ignored
        add_entry("red_and_b_part", BW_AND, 1, 0, 64'hffff_ffff_ffff_ffbf,
                  64'hfe00_fd00_00f7_00ef, 8'hff, 8'ha5, 0, 0);
        add_entry("red_or_h_part", BW_OR, 1, 1, 64'h100, 64'h0, 8'hff, 8'hcc, 2, 0);
        add_entry("red_xor_w_part", BW_XOR, 1, 2, 64'h0, 64'h0, 8'hff, 8'hf0, 3, 0);
        add_entry("red_and_d_none", BW_AND, 1, 3, 64'h0, 64'h0, 8'hff, 8'h00, 3, 0);
        add_entry("ew_xor_prev", BW_XOR, 0, 1, 64'h0, 64'h0, 8'hff, 8'hff, 3, 1);
        add_entry("red_or_after_ew", BW_OR, 1, 2, 64'h0, 64'h0, 8'hff, 8'hff, 3, 3);
    endtask

    // Full four-phase handshake, entered and left on a falling edge
    task automatic run_entry(input int idx);
        word_t          exp_res;
        riscv_v_valid_t exp_valid;
        word_t          mask;
        int             wait_cycles;
        test_failed = 1'b0;
        compute_expected(tbl_op[idx], tbl_red[idx], tbl_osize[idx], tbl_srca[idx],
                         tbl_srcb[idx], tbl_srca_valid[idx], tbl_srcb_valid[idx],
                         exp_res, exp_valid);
        op         = tbl_op[idx];
        is_reduct  = tbl_red[idx];
        osize      = tbl_osize[idx];
        srca       = tbl_srca[idx];
        srcb       = tbl_srcb[idx];
        srca_valid = tbl_srca_valid[idx];
        srcb_valid = tbl_srcb_valid[idx];
        req        = 1'b1;
        wait_cycles = 0;
        while (!ack) begin
            @(negedge clk);
            wait_cycles++;
        end
        check_value(tbl_name[idx], "ack latency", word_t'(2), word_t'(wait_cycles));
        // Back-pressure by holding req
        repeat (tbl_hold[idx]) @(negedge clk);
        check_value(tbl_name[idx], "ack held", word_t'(1), word_t'(ack));
        mask = valid_to_mask(exp_valid);
        check_value(tbl_name[idx], "result", exp_res & mask, result & mask);
        check_value(tbl_name[idx], "result_valid", word_t'(exp_valid), word_t'(result_valid));
        if (tbl_red[idx]) check_value(tbl_name[idx], "upper bytes", '0, result & ~mask);
        req = 1'b0;
        @(negedge clk);
        check_value(tbl_name[idx], "ack fall", '0, word_t'(ack));
        if (test_failed) fail_count++;
        $display("Test %0d %s: %s", idx, tbl_name[idx], test_failed ? "FAIL" : "ok");
    endtask

    initial begin
        rst_n      = 1'b0;
        req        = 1'b0;
        op         = BW_AND;
        is_reduct  = 1'b0;
        osize      = '0;
        srca       = '0;
        srca_valid = '0;
        srcb       = '0;
        srcb_valid = '0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset", "ack", '0, word_t'(ack));
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        $display("Tests %0d, good %0d, bad %0d, errors %0d", n_entries,
                 n_entries - fail_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : riscv_v_bw_tb

// ==== files.f ====
+incdir+verilog
verilog/riscv_v_pkg.sv
verilog/riscv_v_osize_decode.sv
verilog/riscv_v_bw_and.sv
verilog/riscv_v_bw_or.sv
verilog/riscv_v_bw_xor.sv
verilog/riscv_v_bw_ctrl.sv
verilog/riscv_v_bw_unit.sv
bench/riscv_v_bw_chk.sv
bench/riscv_v_bw_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the bitwise lane regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module riscv_v_bw_tb \
    -o riscv_v_bw_sim

./obj_dir/riscv_v_bw_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
fi
exit 1
